/* include/icache_defs.svh */
// Instruction cache geometry

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch address width in bits
`define ICACHE_ADDR_W 32

// One cache line, filled by a single memory read
`define ICACHE_LINE_W 256

`define ICACHE_SETS 64   // Sets per way
`define ICACHE_WAYS 2    // Associativity

// Doubleword handed to the instruction queue
`define ICACHE_INSTR_W 64

`endif

/* source/icache_pkg.sv */
// Instruction cache types

`include "icache_defs.svh"

package icache_pkg;

	// Full fetch address as produced by the PC generator
	typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;

	// Address bits above set index and line offset
	typedef logic [`ICACHE_ADDR_W-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_W/8)-1:0] tag_t;

	typedef logic [$clog2(`ICACHE_SETS)-1:0] set_idx_t;                   // Line index
	typedef logic [$clog2(`ICACHE_LINE_W/`ICACHE_INSTR_W)-1:0] dw_sel_t;  // Doubleword in line

	// One bit per way, used both one-hot and as a valid vector
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	typedef logic [`ICACHE_INSTR_W-1:0] instr_t;

	// Fetch controller states
	typedef enum logic [2:0] {
		IDLE,     // Ready for a fetch address
		LOOKUP,   // Tag and data read back, compare
		MISS_AR,  // Line address offered to memory
		MISS_R,   // Waiting for the line
		HOLD,     // Output valid, waiting for the queue
		FLUSH     // Walking the sets to clear valid bits
	} ctrl_state_t;

endpackage

/* source/mem_bus_pkg.sv */
// Memory read port types

`include "icache_defs.svh"

package mem_bus_pkg;

	// Whole line as returned on the read data channel
	typedef logic [`ICACHE_LINE_W-1:0] line_t;

	typedef logic [1:0] rresp_t;

	// Any other code is an error and becomes a fetch fault
	localparam rresp_t RESP_OKAY = 2'b00;

endpackage

/* source/gen_sram.sv */
// Simple dual port SRAM

module gen_sram #(
	parameter int DW = 32,  // Word width
	parameter int AW = 6    // Address width
) (
	input  logic          CLK,
	input  logic          en_r,
	input  logic [AW-1:0] addr_r,
	output logic [DW-1:0] data_r,
	input  logic          en_w,
	input  logic [AW-1:0] addr_w,
	input  logic [DW-1:0] data_w
);

	logic [DW-1:0] mem [2**AW];

	// Read of a word written in the same cycle returns the old contents
	always_ff @(posedge CLK) begin
		if (en_w) begin
			mem[addr_w] <= data_w;
		end
		if (en_r) begin
			data_r <= mem[addr_r];  // Holds until the next read
		end
	end

endmodule

/* source/victim_select.sv */
// Fill way selection

module victim_select (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  icache_pkg::way_mask_t valid,
	output icache_pkg::way_mask_t fill_way
);

	import icache_pkg::*;

	logic [15:0] lfsr;
	way_mask_t   free_way;
	logic        all_valid;

	// Taps 16, 14, 13, 11 give a maximal length sequence
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= 16'hace1;  // Any non-zero seed
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	// Lowest numbered invalid way wins
	always_comb begin
		free_way = '0;
		for (int w = $bits(way_mask_t) - 1; w >= 0; w--) begin
			if (!valid[w]) begin
				free_way = way_mask_t'(1) << w;
			end
		end
	end

	assign all_valid = &valid;

	// Set full, pick pseudo-randomly
	assign fill_way = all_valid ? (way_mask_t'(1) << lfsr[0]) : free_way;

	fill_way_onehot: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot(fill_way));

endmodule

/* source/icache_ctrl.sv */
// Instruction cache controller

`include "icache_defs.svh"

module icache_ctrl (
	input  logic                                        CLK,
	input  logic                                        arst_n,
	input  logic                                        flush,
	input  icache_pkg::fetch_addr_t                     fetch_addr,
	input  logic                                        fetch_valid,
	output logic                                        fetch_ready,

	output icache_pkg::fetch_addr_t                     instr_pc,
	output icache_pkg::instr_t                          instr_data,
	output logic                                        instr_fault,
	output logic                                        instr_valid,
	input  logic                                        instr_ready,

	output icache_pkg::fetch_addr_t                     mem_ar_addr,
	output logic                                        mem_ar_valid,
	input  logic                                        mem_ar_ready,
	input  mem_bus_pkg::line_t                          mem_r_data,
	input  mem_bus_pkg::rresp_t                         mem_r_resp,
	input  logic                                        mem_r_valid,
	output logic                                        mem_r_ready,

	output logic                                        rd_en,
	output icache_pkg::set_idx_t                        rd_set,
	input  logic [`ICACHE_WAYS-1:0][$bits(icache_pkg::tag_t):0] tag_rd,
	input  mem_bus_pkg::line_t [`ICACHE_WAYS-1:0]       line_rd,
	output icache_pkg::way_mask_t                       wr_way,
	output icache_pkg::set_idx_t                        wr_set,
	output logic [$bits(icache_pkg::tag_t):0]           tag_wr,
	output mem_bus_pkg::line_t                          line_wr,

	input  icache_pkg::way_mask_t                       fill_way,
	output icache_pkg::way_mask_t                       way_valid
);

	import icache_pkg::*;
	import mem_bus_pkg::*;

	localparam int OFS_W  = $clog2(`ICACHE_LINE_W / 8);   // Byte offset in a line
	localparam int DW_LSB = $clog2(`ICACHE_INSTR_W / 8);  // Byte offset in a doubleword
	localparam int SET_W  = $bits(set_idx_t);
	localparam int TAG_W  = $bits(tag_t);

	ctrl_state_t state;
	set_idx_t    walk_cnt;
	logic        discard;    // Outstanding line belongs to a flushed request
	fetch_addr_t req_addr;

	tag_t        req_tag;
	set_idx_t    req_set;
	dw_sel_t     req_dw;
	way_mask_t   hit_way;
	line_t       hit_line;
	logic        r_done;
	logic        fill_ok;

	assign req_tag = req_addr[OFS_W + SET_W +: TAG_W];
	assign req_set = req_addr[OFS_W +: SET_W];
	assign req_dw  = req_addr[DW_LSB +: $bits(dw_sel_t)];

	// A request on a flush cycle is not taken
	assign fetch_ready = (state == IDLE) && !flush;
	assign rd_en       = fetch_valid && fetch_ready;
	assign rd_set      = fetch_addr[OFS_W +: SET_W];

	// Tag compare on the registered SRAM outputs
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_valid[w] = tag_rd[w][TAG_W];
			hit_way[w]   = tag_rd[w][TAG_W] && (tag_rd[w][TAG_W-1:0] == req_tag);
			if (hit_way[w]) begin
				hit_line = hit_line | line_rd[w];
			end
		end
	end

	assign mem_ar_valid = (state == MISS_AR);
	assign mem_ar_addr  = {req_addr[`ICACHE_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};  // Line aligned
	assign mem_r_ready  = (state == MISS_R);
	assign instr_valid  = (state == HOLD);

	assign r_done  = mem_r_ready && mem_r_valid;
	assign fill_ok = r_done && !discard && !flush && (mem_r_resp == RESP_OKAY);

	// Flush walk clears both ways of one set per cycle
	assign wr_way  = (state == FLUSH) ? '1 : (fill_ok ? fill_way : '0);
	assign wr_set  = (state == FLUSH) ? walk_cnt : req_set;
	assign tag_wr  = (state == FLUSH) ? '0 : {1'b1, req_tag};
	assign line_wr = mem_r_data;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state    <= FLUSH;  // Tags are unknown out of reset
			walk_cnt <= '0;
			discard  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (flush) begin
						state <= FLUSH;
					end else if (fetch_valid) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (flush) begin
						state <= FLUSH;
					end else begin
						state <= (|hit_way) ? HOLD : MISS_AR;
					end
				end
				// The address must still go out, so a flush only marks the read
				MISS_AR: begin
					if (flush) begin
						discard <= 1'b1;
					end
					if (mem_ar_ready) begin
						state <= MISS_R;
					end
				end
				MISS_R: begin
					if (mem_r_valid) begin
						discard <= 1'b0;
						state   <= (discard || flush) ? FLUSH : HOLD;
					end else if (flush) begin
						discard <= 1'b1;
					end
				end
				HOLD: begin
					if (flush) begin
						state <= FLUSH;
					end else if (instr_ready) begin
						state <= IDLE;
					end
				end
				FLUSH: begin
					walk_cnt <= walk_cnt + 1'b1;  // Wraps back to zero on exit
					if (walk_cnt == set_idx_t'(`ICACHE_SETS - 1)) begin
						state <= IDLE;
					end
				end
				default: state <= FLUSH;
			endcase
		end
	end

	// Request and output registers
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			req_addr <= fetch_addr;
		end
		if (state == LOOKUP) begin
			instr_pc    <= req_addr;  // Only shown if the compare hit
			instr_data  <= hit_line[req_dw * `ICACHE_INSTR_W +: `ICACHE_INSTR_W];
			instr_fault <= 1'b0;
		end else if (r_done) begin
			instr_pc    <= req_addr;
			instr_data  <= mem_r_data[req_dw * `ICACHE_INSTR_W +: `ICACHE_INSTR_W];
			instr_fault <= (mem_r_resp != RESP_OKAY);
		end
	end

	ar_held: assert property (@(posedge CLK) disable iff (!arst_n)
		mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_addr));

	out_held: assert property (@(posedge CLK) disable iff (!arst_n)
		instr_valid && !instr_ready && !flush
		|=> instr_valid && $stable(instr_pc) && $stable(instr_data));

endmodule

/* source/ifetch_top.sv */
// Instruction fetch unit

`include "icache_defs.svh"

module ifetch_top (
	input  logic                    CLK,
	input  logic                    arst_n,
	input  logic                    flush,

	input  icache_pkg::fetch_addr_t fetch_addr,
	input  logic                    fetch_valid,
	output logic                    fetch_ready,

	output icache_pkg::fetch_addr_t instr_pc,
	output icache_pkg::instr_t      instr_data,
	output logic                    instr_fault,
	output logic                    instr_valid,
	input  logic                    instr_ready,

	output icache_pkg::fetch_addr_t mem_ar_addr,
	output logic                    mem_ar_valid,
	input  logic                    mem_ar_ready,
	input  mem_bus_pkg::line_t      mem_r_data,
	input  mem_bus_pkg::rresp_t     mem_r_resp,
	input  logic                    mem_r_valid,
	output logic                    mem_r_ready
);

	import icache_pkg::*;
	import mem_bus_pkg::*;

	localparam int TAG_ENTRY_W = $bits(tag_t) + 1;  // Valid bit on top of the tag
	localparam int SET_W       = $bits(set_idx_t);

	logic                                     rd_en;
	set_idx_t                                 rd_set;
	logic [`ICACHE_WAYS-1:0][TAG_ENTRY_W-1:0] tag_rd;
	line_t [`ICACHE_WAYS-1:0]                 line_rd;
	way_mask_t                                wr_way;
	set_idx_t                                 wr_set;
	logic [TAG_ENTRY_W-1:0]                   tag_wr;
	line_t                                    line_wr;
	way_mask_t                                fill_way;
	way_mask_t                                way_valid;

	icache_ctrl u_ctrl (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.flush        (flush),
		.fetch_addr   (fetch_addr),
		.fetch_valid  (fetch_valid),
		.fetch_ready  (fetch_ready),
		.instr_pc     (instr_pc),
		.instr_data   (instr_data),
		.instr_fault  (instr_fault),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.mem_ar_addr  (mem_ar_addr),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_r_data   (mem_r_data),
		.mem_r_resp   (mem_r_resp),
		.mem_r_valid  (mem_r_valid),
		.mem_r_ready  (mem_r_ready),
		.rd_en        (rd_en),
		.rd_set       (rd_set),
		.tag_rd       (tag_rd),
		.line_rd      (line_rd),
		.wr_way       (wr_way),
		.wr_set       (wr_set),
		.tag_wr       (tag_wr),
		.line_wr      (line_wr),
		.fill_way     (fill_way),
		.way_valid    (way_valid)
	);

	victim_select u_victim (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.valid    (way_valid),
		.fill_way (fill_way)
	);

	// Tag and data array per way, both read on fetch acceptance
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		gen_sram #(.DW(TAG_ENTRY_W), .AW(SET_W)) u_tag (
			.CLK    (CLK),
			.en_r   (rd_en),
			.addr_r (rd_set),
			.data_r (tag_rd[w]),
			.en_w   (wr_way[w]),
			.addr_w (wr_set),
			.data_w (tag_wr)
		);

		gen_sram #(.DW($bits(line_t)), .AW(SET_W)) u_data (
			.CLK    (CLK),
			.en_r   (rd_en),
			.addr_r (rd_set),
			.data_r (line_rd[w]),
			.en_w   (wr_way[w]),
			.addr_w (wr_set),
			.data_w (line_wr)
		);
	end

endmodule

/* tb/mem_model.sv */
// Memory read slave

module mem_model (
	input  logic         CLK,
	input  logic         arst_n,
	input  logic [2:0]   ar_delay,      // Cycles before the next address is taken
	input  logic [2:0]   r_delay,       // Cycles before the line is returned
	input  logic [31:0]  mem_ar_addr,
	input  logic         mem_ar_valid,
	output logic         mem_ar_ready,
	output logic [255:0] mem_r_data,
	output logic [1:0]   mem_r_resp,
	output logic         mem_r_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	logic        pend;       // Address taken, line not yet returned
	logic [2:0]  wait_cnt;
	logic [31:0] line_addr;

	// Content of the doubleword at a doubleword aligned address
	function automatic logic [63:0] word_at(input logic [31:0] a);
		return {a ^ 32'h5bd1e995, (a * 32'h9e3779b1) ^ 32'hc8ab0000};
	endfunction

	function automatic logic [255:0] line_at(input logic [31:0] a);
		logic [255:0] l;
		for (int i = 0; i < 4; i++) begin
			l[i*64 +: 64] = word_at(a + 32'(i * 8));
		end
		return l;
	endfunction

	// Each pulse is one cycle wide, the DUT is always ready when it arrives
	always @(negedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mem_ar_ready <= 1'b0;
			mem_r_valid  <= 1'b0;
			mem_r_data   <= '0;
			mem_r_resp   <= 2'b00;
			pend         <= 1'b0;
			wait_cnt     <= 3'd2;
			line_addr    <= '0;
		end else begin
			mem_ar_ready <= 1'b0;
			mem_r_valid  <= 1'b0;
			if (mem_ar_ready) begin
				pend     <= 1'b1;
				wait_cnt <= r_delay;
			end else if (mem_r_valid) begin
				pend     <= 1'b0;
				wait_cnt <= ar_delay;
			end else if (wait_cnt != 3'd0) begin
				wait_cnt <= wait_cnt - 3'd1;
			end else if (pend) begin
				mem_r_valid <= 1'b1;
				mem_r_data  <= line_at(line_addr);
				mem_r_resp  <= (line_addr[31:14] == 18'h20001) ? 2'b10 : 2'b00;  // SLVERR region
			end else if (mem_ar_valid) begin
				mem_ar_ready <= 1'b1;
				line_addr    <= mem_ar_addr;
			end
		end
	end

endmodule

/* tb/tb_ifetch.sv */
// Instruction fetch testbench

module tb_ifetch;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS       = 10;
	localparam int NUM_RAND     = 60;
	localparam int NUM_DIRECTED = 16;
	localparam int NUM_FLUSH    = NUM_RAND + 4;
	localparam int WATCH_CYCLES = 200 * (NUM_RAND + NUM_DIRECTED) + 100 * NUM_FLUSH + 10;

	logic         CLK = 1'b0;
	logic         arst_n, flush, fetch_valid, fetch_ready;
	logic [31:0]  fetch_addr, instr_pc, mem_ar_addr;
	logic [63:0]  instr_data;
	logic         instr_fault, instr_valid, instr_ready;
	logic         mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
	logic [255:0] mem_r_data;
	logic [1:0]   mem_r_resp;
	logic [2:0]   ar_delay, r_delay;

	logic [31:0] rng_state = 32'hc8ab;
	logic [31:0] req_q[$];      // Accepted, not yet delivered
	logic [31:0] last_acc, prev_pc;
	logic [63:0] prev_data;
	logic        held_prev, stall_roll;
	logic        r_pend;        // Line address taken, data not yet returned
	int          ready_mode;    // 0 always ready, 1 random stalls, 2 never ready
	int          ar_cnt, dlv_cnt, n;

	ifetch_top UUT (.*);

	mem_model u_mem (.*);

	always #(CLK_NS / 2) CLK = ~CLK;

	function logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 16;
	endfunction

	// Small pool of lines so hits, evictions and SLVERR lines all occur
	function logic [31:0] random_addr();
		logic [31:0] r;
		logic [31:0] a;
		r = next_rand();
		a = 32'h8000_0000;
		a[12:11] = r[1:0];
		a[6:5]   = r[3:2];
		a[4:3]   = r[5:4];
		a[14]    = (r[8:6] == 3'd0);
		return a;
	endfunction

	function automatic logic [63:0] expected_word(input logic [31:0] pc);
		logic [31:0] a;
		a = {pc[31:3], 3'b000};
		return {a ^ 32'h5bd1e995, (a * 32'h9e3779b1) ^ 32'hc8ab0000};
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	always @(negedge CLK) begin
		instr_ready = (ready_mode == 0) || (ready_mode == 1 && stall_roll);
	end

	// Reference model, sampled where all inputs and outputs are settled
	always begin
		@(negedge CLK);
		#2;
		if (arst_n) begin
			if (held_prev) begin
				check_eq(64'(instr_valid), 64'd1, "instr_valid dropped while stalled");
				check_eq(64'(instr_pc), 64'(prev_pc), "instr_pc changed while stalled");
				check_eq(instr_data, prev_data, "instr_data changed while stalled");
			end
			if (instr_valid) check_eq(64'(fetch_ready), 64'd0, "fetch_ready with held output");
			check_eq(64'(mem_r_ready), 64'(r_pend), "mem_r_ready");
			if (fetch_valid && fetch_ready) begin
				req_q.push_back(fetch_addr);
				last_acc = fetch_addr;
			end
			if (mem_ar_valid && mem_ar_ready) begin
				check_eq(64'(mem_ar_addr), 64'({last_acc[31:5], 5'd0}), "line read address");
				ar_cnt++;
				r_pend = 1'b1;
			end
			if (mem_r_valid && mem_r_ready) r_pend = 1'b0;
			if (instr_valid && instr_ready) begin
				check_eq(64'(req_q.size() != 0), 64'd1, "instruction with no request");
				check_eq(64'(instr_pc), 64'(req_q[0]), "instr_pc");
				check_eq(64'(instr_fault), 64'(req_q[0][31:14] == 18'h20001), "instr_fault");
				if (!instr_fault) check_eq(instr_data, expected_word(req_q[0]), "instr_data");
				void'(req_q.pop_front());
				dlv_cnt++;
			end
			if (flush) req_q.delete();
		end
		held_prev  = arst_n && instr_valid && !instr_ready && !flush;
		prev_pc    = instr_pc;
		prev_data  = instr_data;
		stall_roll = (next_rand() % 32'd3) != 32'd0;
		ar_delay   = 3'(next_rand() % 32'd6);
		r_delay    = 3'(next_rand() % 32'd6);
	end

	task automatic fetch_one(input logic [31:0] a);
		int acc;
		acc = dlv_cnt + req_q.size();
		fetch_addr  = a;
		fetch_valid = 1'b1;
		@(negedge CLK);
		while (dlv_cnt + req_q.size() == acc) @(negedge CLK);
		fetch_valid = 1'b0;
	endtask

	task automatic fetch_wait(input logic [31:0] a);
		fetch_one(a);
		while (req_q.size() != 0) @(negedge CLK);
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge CLK);
		while (!fetch_ready || req_q.size() != 0) @(negedge CLK);
	endtask

	initial begin
		#(CLK_NS * WATCH_CYCLES);
		$display("Watchdog expired, the DUT stopped responding");
		$display("TEST FAILED");
		$fatal(1, "Hang");
	end

	initial begin
		arst_n = 1'b0;
		flush = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		instr_ready = 1'b0;
		ready_mode = 1;
		held_prev = 1'b0;
		stall_roll = 1'b1;
		r_pend = 1'b0;
		ar_delay = 3'd1;
		r_delay = 3'd1;
		last_acc = '0;
		ar_cnt = 0;
		dlv_cnt = 0;
		repeat (5) @(negedge CLK);
		arst_n = 1'b1;

		// Random fetches with stalls and flushes at random points
		for (int i = 0; i < NUM_RAND; i++) begin
			fetch_one(random_addr());
			if (next_rand() % 32'd10 == 32'd0) begin
				repeat (next_rand() % 32'd6) @(negedge CLK);
				pulse_flush();
			end
		end
		wait_idle();
		ready_mode = 0;

		// Fill then hit in the same line, SLVERR line is never filled
		pulse_flush();
		wait_idle();
		fetch_wait(32'h8000_0120);
		n = ar_cnt;
		fetch_wait(32'h8000_0128);
		check_eq(64'(ar_cnt), 64'(n), "transfers after a hit on a filled line");
		fetch_wait(32'h8000_4200);
		n = ar_cnt;
		fetch_wait(32'h8000_4200);
		check_eq(64'(ar_cnt), 64'(n + 1), "transfers after repeating a faulting fetch");

		// Two lines of one set land in both free ways
		pulse_flush();
		wait_idle();
		n = ar_cnt;
		fetch_wait(32'h8000_0040);
		fetch_wait(32'h8000_0848);
		repeat (3) begin
			fetch_wait(32'h8000_0050);
			fetch_wait(32'h8000_0858);
		end
		check_eq(64'(ar_cnt), 64'(n + 2), "transfers while alternating two lines of a set");

		// Output held under back-pressure, monitor checks stability
		ready_mode = 2;
		fetch_one(32'h8000_0040);
		repeat (12) @(negedge CLK);
		check_eq(64'(instr_valid), 64'd1, "instr_valid while instr_ready low");
		ready_mode = 0;
		wait_idle();

		// Flush while a miss is outstanding
		pulse_flush();
		wait_idle();
		n = dlv_cnt;
		fetch_one(32'h8000_0260);
		while (!mem_ar_valid) @(negedge CLK);
		pulse_flush();
		wait_idle();
		check_eq(64'(dlv_cnt), 64'(n), "delivery for a flushed miss");
		n = ar_cnt;
		fetch_wait(32'h8000_0260);
		check_eq(64'(ar_cnt), 64'(n + 1), "transfers for a line dropped by flush");

		$display("TEST OK");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
source/icache_pkg.sv
source/mem_bus_pkg.sv
source/gen_sram.sv
source/victim_select.sv
source/icache_ctrl.sv
source/ifetch_top.sv
tb/mem_model.sv
tb/tb_ifetch.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_ifetch -o tb_ifetch > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_ifetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
